// ==== Makefile ====
TOP := pmu_tb
SOURCES := $(shell cat project.f)

obj_dir/V$(TOP): project.f $(SOURCES)
	verilator --binary --assert -j 0 --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP) +verilator+error+limit+100); echo "$$out"; \
	echo "$$out" | grep -q '^Result: PASSED$$'

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== dv/pmu_checker.sv ====
//----------------------------------------------------------
// Concurrent assertions on the PMU core
// Bound into pmu_top. Watches both interrupts, the sticky
// overflow vector and the overflow controls.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_checker (
    input logic                clk_i,
    input logic                reset_i,
    input logic                ovf_en_i,
    input logic                ovf_softrst_i,
    input pmu_pkg::event_vec_t ovf_vect_i,
    input logic                intr_overflow_i,
    input logic                intr_quota_i
);

    // Count of failed assertions
    int fail_count = 0;

    // Interrupts come out of reset low
    intr_low_after_reset: assert property (@(posedge clk_i)
        reset_i |=> !intr_overflow_i && !intr_quota_i)
        else begin
            $error("interrupt high in the cycle after reset");
            fail_count++;
        end

    // Sticky bits only fall through reset or overflow soft reset
    ovf_vect_sticky: assert property (@(posedge clk_i)
        (!reset_i && !ovf_softrst_i) |=> ((ovf_vect_i & $past(ovf_vect_i)) == $past(ovf_vect_i)))
        else begin
            $error("overflow vector bit cleared without reset");
            fail_count++;
        end

    // Registered interrupt needs the enable one cycle earlier
    ovf_intr_needs_en: assert property (@(posedge clk_i)
        (!reset_i && intr_overflow_i) |-> $past(ovf_en_i))
        else begin
            $error("overflow interrupt high while overflow was disabled");
            fail_count++;
        end

endmodule

bind pmu_top pmu_checker u_checker (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .ovf_en_i        (ovf_en),
    .ovf_softrst_i   (ovf_softrst),
    .ovf_vect_i      (ovf_vect),
    .intr_overflow_i (intr_overflow_o),
    .intr_quota_i    (intr_quota_o)
);

// ==== dv/pmu_monitor.sv ====
//----------------------------------------------------------
// Reference model of the PMU core
// Steps at each rising edge from the DUT inputs and checks
// the DUT outputs at the falling edge, counting mismatches.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_monitor (
    input  logic                clk_i,
    input  logic                reset_i,
    input  pmu_pkg::reg_t       regs_i     [pmu_pkg::TOTAL_NREGS],
    input  pmu_pkg::reg_t       dut_regs_i [pmu_pkg::TOTAL_NREGS],
    input  logic                wrapper_we_i,
    input  pmu_pkg::event_vec_t events_i,
    input  logic                intr_overflow_i,
    input  logic                intr_quota_i,
    output int                  errors_o
);

    pmu_pkg::reg_t       cnt_m [pmu_pkg::N_COUNTERS];
    pmu_pkg::event_vec_t vect_m;
    pmu_pkg::reg_t       sum_m;
    logic                intr_ovf_m;
    logic                intr_quota_m;
    int                  errors = 0;

    assign errors_o = errors;

    task automatic compare(string name, pmu_pkg::reg_t expected, pmu_pkg::reg_t actual);
        if (actual !== expected) begin
            $display("Fail: %s expected %h actual %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    //----------------------------------------------------------
    // Model step on the state before this edge
    //----------------------------------------------------------

    always @(posedge clk_i) begin : model_step
        pmu_pkg::reg_t       cfg;
        pmu_pkg::event_vec_t ev;
        pmu_pkg::reg_t       sum;
        cfg = regs_i[pmu_pkg::CFG_IDX];
        case (pmu_pkg::selftest_mode_e'(cfg[pmu_pkg::CFG_SELFTEST_LSB +: 2]))
            pmu_pkg::SELFTEST_ALL_ON:  ev = '1;
            pmu_pkg::SELFTEST_ALL_OFF: ev = '0;
            pmu_pkg::SELFTEST_ONE_ON:  ev = pmu_pkg::event_vec_t'(1);
            default:                   ev = events_i;
        endcase
        // Quota compare sees the sum from the previous edge
        if (reset_i || cfg[pmu_pkg::CFG_QUOTA_SOFTRST_BIT])
            intr_quota_m = 1'b0;
        else if (sum_m >= regs_i[pmu_pkg::QUOTA_LIMIT_IDX])
            intr_quota_m = 1'b1;
        sum = '0;
        for (int i = 0; i < pmu_pkg::N_COUNTERS; i++)
            if (regs_i[pmu_pkg::QUOTA_MASK_IDX][i]) sum = sum + cnt_m[i];
        sum_m = reset_i ? '0 : sum;
        // Interrupt from the old vector before the vector grows
        if (reset_i || cfg[pmu_pkg::CFG_OVF_SOFTRST_BIT]) begin
            intr_ovf_m = 1'b0;
            vect_m     = '0;
        end else begin
            intr_ovf_m = cfg[pmu_pkg::CFG_OVF_EN_BIT] &&
                         |(vect_m & pmu_pkg::event_vec_t'(regs_i[pmu_pkg::OVF_MASK_IDX]));
            for (int i = 0; i < pmu_pkg::N_COUNTERS; i++)
                if (cnt_m[i] == '1) vect_m[i] = 1'b1;
        end
        // Counter priority is reset, load, soft reset, increment
        for (int i = 0; i < pmu_pkg::N_COUNTERS; i++) begin
            if (reset_i) cnt_m[i] = '0;
            else if (wrapper_we_i) cnt_m[i] = regs_i[pmu_pkg::COUNTER_BASE + i];
            else if (cfg[pmu_pkg::CFG_SOFTRST_BIT]) cnt_m[i] = '0;
            else if (cfg[pmu_pkg::CFG_EN_BIT] && ev[i]) cnt_m[i] = cnt_m[i] + 1;
        end
    end

    // Outputs settled by the falling edge
    always @(negedge clk_i) begin
        if (!reset_i) begin
            for (int i = 0; i < pmu_pkg::N_COUNTERS; i++)
                compare($sformatf("regs_o[%0d]", pmu_pkg::COUNTER_BASE + i), cnt_m[i],
                        dut_regs_i[pmu_pkg::COUNTER_BASE + i]);
            compare("regs_o[11]", pmu_pkg::reg_t'(vect_m), dut_regs_i[pmu_pkg::OVF_VECT_IDX]);
            // Software words come back as the wrapper holds them
            compare("regs_o[0]", regs_i[pmu_pkg::CFG_IDX], dut_regs_i[pmu_pkg::CFG_IDX]);
            compare("regs_o[10]", regs_i[pmu_pkg::OVF_MASK_IDX],
                    dut_regs_i[pmu_pkg::OVF_MASK_IDX]);
            compare("regs_o[12]", regs_i[pmu_pkg::QUOTA_MASK_IDX],
                    dut_regs_i[pmu_pkg::QUOTA_MASK_IDX]);
            compare("regs_o[13]", regs_i[pmu_pkg::QUOTA_LIMIT_IDX],
                    dut_regs_i[pmu_pkg::QUOTA_LIMIT_IDX]);
            compare("intr_overflow_o", pmu_pkg::reg_t'(intr_ovf_m),
                    pmu_pkg::reg_t'(intr_overflow_i));
            compare("intr_quota_o", pmu_pkg::reg_t'(intr_quota_m), pmu_pkg::reg_t'(intr_quota_i));
        end
    end

endmodule

// ==== dv/pmu_tb.sv ====
//----------------------------------------------------------
// Testbench of the PMU core
// Drives the wrapper register file, the write level and the
// events of pmu_top through five tests; pmu_monitor checks
// every cycle. One line per test, then the closing counts.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_tb;

    localparam int SEED         = 87;
    localparam int CLK_PERIOD   = 100;
    // Test lengths in cycles, rounded up
    localparam int LEN_COUNT    = 300;
    localparam int LEN_SELFTEST = 80;
    localparam int LEN_LOAD     = 20;
    localparam int LEN_OVF      = 40;
    localparam int LEN_QUOTA    = 80;
    localparam int TOTAL_CYCLES = LEN_COUNT + LEN_SELFTEST + LEN_LOAD + LEN_OVF + LEN_QUOTA;

    logic                clk = 1'b0;
    logic                reset;
    pmu_pkg::reg_t       regs     [pmu_pkg::TOTAL_NREGS];
    pmu_pkg::reg_t       regs_out [pmu_pkg::TOTAL_NREGS];
    logic                wrapper_we;
    pmu_pkg::event_vec_t events;
    logic                intr_overflow;
    logic                intr_quota;
    int                  mon_errors;
    int                  last_errors = 0;
    int                  n_tests = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    pmu_top uut (
        .clk_i           (clk),
        .reset_i         (reset),
        .regs_i          (regs),
        .regs_o          (regs_out),
        .wrapper_we_i    (wrapper_we),
        .events_i        (events),
        .intr_overflow_o (intr_overflow),
        .intr_quota_o    (intr_quota)
    );

    pmu_monitor u_monitor (
        .clk_i           (clk),
        .reset_i         (reset),
        .regs_i          (regs),
        .dut_regs_i      (regs_out),
        .wrapper_we_i    (wrapper_we),
        .events_i        (events),
        .intr_overflow_i (intr_overflow),
        .intr_quota_i    (intr_quota),
        .errors_o        (mon_errors)
    );

    // Model mismatches plus failed assertions
    function automatic int total_errors();
        return mon_errors + uut.u_checker.fail_count;
    endfunction

    function automatic pmu_pkg::reg_t cfg_word(pmu_pkg::selftest_mode_e mode, logic en,
                                               logic ovf_en);
        pmu_pkg::reg_t w;
        w = '0;
        w[pmu_pkg::CFG_EN_BIT]     = en;
        w[pmu_pkg::CFG_OVF_EN_BIT] = ovf_en;
        w[pmu_pkg::CFG_SELFTEST_LSB +: pmu_pkg::SELFTEST_WIDTH] = mode;
        return w;
    endfunction

    // Inputs move 10 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #10;
    endtask

    task automatic run_events(int cycles);
        repeat (cycles) begin
            events = pmu_pkg::event_vec_t'($urandom);
            tick();
        end
    endtask

    // One cycle high on a configuration bit
    task automatic pulse_cfg_bit(int bit_pos);
        regs[pmu_pkg::CFG_IDX][bit_pos] = 1'b1;
        run_events(1);
        regs[pmu_pkg::CFG_IDX][bit_pos] = 1'b0;
    endtask

    // Counter words for the wrapper, some just below all ones
    task automatic write_counters(logic near_max);
        for (int i = 0; i < pmu_pkg::N_COUNTERS; i++)
            regs[pmu_pkg::COUNTER_BASE + i] = (near_max && ($urandom % 3 != 0)) ?
                                              '1 - ($urandom % 4) : $urandom;
        wrapper_we = 1'b1;
    endtask

    task automatic end_test(string name);
        int now_errors;
        events = '0;
        tick();
        now_errors = total_errors();
        $display("Test %0d %s: %0d errors", n_tests + 1, name, now_errors - last_errors);
        last_errors = now_errors;
        n_tests++;
    endtask

    // Watchdog
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the test sequence finished");
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        reset      = 1'b1;
        wrapper_we = 1'b0;
        events     = '0;
        for (int r = 0; r < pmu_pkg::TOTAL_NREGS; r++) regs[r] = '0;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;

        // Random counting
        regs[pmu_pkg::CFG_IDX] = cfg_word(pmu_pkg::SELFTEST_OFF, 1'b1, 1'b0);
        run_events(LEN_COUNT);
        end_test("random counting");

        // Each self-test mode in turn
        for (int m = 0; m < 4; m++) begin
            regs[pmu_pkg::CFG_IDX] = cfg_word(pmu_pkg::selftest_mode_e'(m), 1'b1, 1'b0);
            run_events(LEN_SELFTEST / 4);
        end
        regs[pmu_pkg::CFG_IDX] = cfg_word(pmu_pkg::SELFTEST_OFF, 1'b1, 1'b0);
        end_test("self-test modes");

        // Load, soft reset, then load against soft reset and events
        write_counters(1'b0);
        run_events(1);
        wrapper_we = 1'b0;
        run_events(5);
        pulse_cfg_bit(pmu_pkg::CFG_SOFTRST_BIT);
        regs[pmu_pkg::CFG_IDX][pmu_pkg::CFG_SOFTRST_BIT] = 1'b1;
        write_counters(1'b0);
        run_events(1);
        wrapper_we = 1'b0;
        regs[pmu_pkg::CFG_IDX][pmu_pkg::CFG_SOFTRST_BIT] = 1'b0;
        run_events(5);
        end_test("load and soft reset");

        // Overflow with random mask, enable toggled, then cleared
        regs[pmu_pkg::OVF_MASK_IDX] = $urandom;
        write_counters(1'b1);
        run_events(1);
        wrapper_we = 1'b0;
        regs[pmu_pkg::CFG_IDX] = cfg_word(pmu_pkg::SELFTEST_OFF, 1'b1, 1'b1);
        run_events(15);
        regs[pmu_pkg::CFG_IDX][pmu_pkg::CFG_OVF_EN_BIT] = 1'b0;
        run_events(5);
        regs[pmu_pkg::CFG_IDX][pmu_pkg::CFG_OVF_EN_BIT] = 1'b1;
        run_events(5);
        pulse_cfg_bit(pmu_pkg::CFG_OVF_SOFTRST_BIT);
        run_events(5);
        end_test("overflow");

        // Quota from cleared counters, then with an empty mask
        regs[pmu_pkg::QUOTA_MASK_IDX]  = $urandom;
        regs[pmu_pkg::QUOTA_LIMIT_IDX] = 30 + $urandom % 60;
        pulse_cfg_bit(pmu_pkg::CFG_SOFTRST_BIT);
        pulse_cfg_bit(pmu_pkg::CFG_QUOTA_SOFTRST_BIT);
        run_events(50);
        pulse_cfg_bit(pmu_pkg::CFG_QUOTA_SOFTRST_BIT);
        run_events(5);
        regs[pmu_pkg::QUOTA_MASK_IDX] = '0;
        pulse_cfg_bit(pmu_pkg::CFG_QUOTA_SOFTRST_BIT);
        run_events(15);
        end_test("quota");

        $display("Tests: %0d, errors: %0d", n_tests, total_errors());
        if (total_errors() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/pmu_pkg.sv
source/pmu_counters.sv
source/pmu_overflow.sv
source/pmu_quota.sv
source/pmu_top.sv
dv/pmu_checker.sv
dv/pmu_monitor.sv
dv/pmu_tb.sv

// ==== source/pmu_counters.sv ====
//----------------------------------------------------------
// Event counter bank of the PMU core
// Picks the effective events from the self-test mode and
// keeps one counter per event. The wrapper can load the
// counters and software can clear them through soft reset.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_counters (
    input  logic                    clk_i,
    input  logic                    reset_i,
    // Counting enable from the configuration word
    input  logic                    en_i,
    // Clears every counter
    input  logic                    softrst_i,
    // Wrapper write level, loads load_values_i
    input  logic                    load_i,
    input  pmu_pkg::selftest_mode_e selftest_i,
    input  pmu_pkg::reg_t           load_values_i [pmu_pkg::N_COUNTERS],
    input  pmu_pkg::event_vec_t     events_i,
    output pmu_pkg::reg_t           counts_o [pmu_pkg::N_COUNTERS]
);

    //----------------------------------------------------------
    // Self-test event source
    //----------------------------------------------------------

    pmu_pkg::event_vec_t events_eff;
    pmu_pkg::reg_t       count_q [pmu_pkg::N_COUNTERS];

    always_comb begin
        case (selftest_i)
            pmu_pkg::SELFTEST_ALL_ON: begin
                events_eff = '1;
            end
            pmu_pkg::SELFTEST_ALL_OFF: begin
                events_eff = '0;
            end
            pmu_pkg::SELFTEST_ONE_ON: begin
                // Only counter 0 sees an event
                events_eff    = '0;
                events_eff[0] = 1'b1;
            end
            default: begin
                // Normal operation
                events_eff = events_i;
            end
        endcase
    end

    //----------------------------------------------------------
    // Counters
    //----------------------------------------------------------

    // Priority: reset, load, soft reset, increment
    // Wraps from all ones to zero by plain addition
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < pmu_pkg::N_COUNTERS; i++) begin
            if (reset_i) begin
                count_q[i] <= '0;
            end else if (load_i) begin
                count_q[i] <= load_values_i[i];
            end else if (softrst_i) begin
                count_q[i] <= '0;
            end else if (en_i && events_eff[i]) begin
                count_q[i] <= count_q[i] + pmu_pkg::reg_t'(1);
            end
        end
    end

    // Values back to the register map and feature blocks
    assign counts_o = count_q;

endmodule

// ==== source/pmu_overflow.sv ====
//----------------------------------------------------------
// Overflow detection of the PMU core
// Sets a sticky vector bit for each counter that reaches
// all ones and raises a registered interrupt for set bits
// that the mask lets through while overflow is enabled.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_overflow (
    input  logic                clk_i,
    input  logic                reset_i,
    // Overflow interrupt enable
    input  logic                en_i,
    // Clears the vector and the interrupt
    input  logic                softrst_i,
    input  pmu_pkg::reg_t       counts_i [pmu_pkg::N_COUNTERS],
    input  pmu_pkg::event_vec_t mask_i,
    output pmu_pkg::event_vec_t ovf_vect_o,
    output logic                intr_overflow_o
);

    pmu_pkg::event_vec_t at_max;
    pmu_pkg::event_vec_t ovf_vect_q;
    logic                intr_q;

    // Counter about to wrap on its next increment
    always_comb begin
        for (int i = 0; i < pmu_pkg::N_COUNTERS; i++) begin
            at_max[i] = (counts_i[i] == '1);
        end
    end

    // Sticky vector, set one edge after all ones is seen
    always_ff @(posedge clk_i) begin
        if (reset_i || softrst_i) begin
            ovf_vect_q <= '0;
        end else begin
            ovf_vect_q <= ovf_vect_q | at_max;
        end
    end

    // Interrupt follows the registered vector by one cycle
    always_ff @(posedge clk_i) begin
        if (reset_i || softrst_i) begin
            intr_q <= 1'b0;
        end else begin
            intr_q <= en_i && |(ovf_vect_q & mask_i);
        end
    end

    assign ovf_vect_o      = ovf_vect_q;
    assign intr_overflow_o = intr_q;

endmodule

// ==== source/pmu_pkg.sv ====
//----------------------------------------------------------
// Shared definitions of the PMU core
// Widths, register map word indices, bit positions inside
// the configuration word and the self-test encoding.
// All RTL and verification files refer to these by scoped
// names, pmu_pkg::name.
//----------------------------------------------------------

package pmu_pkg;

    //----------------------------------------------------------
    // Widths
    //----------------------------------------------------------

    // One register word, also the counter width
    localparam int REG_WIDTH = 32;
    // Event counters, one per event line
    localparam int N_COUNTERS = 9;
    // Words in the wrapper register file
    localparam int TOTAL_NREGS = 14;
    // Width of the self-test field in the configuration word
    localparam int SELFTEST_WIDTH = 2;

    // Register word or counter value
    typedef logic [REG_WIDTH-1:0] reg_t;
    // One bit per counter: events, masks, overflow vector
    typedef logic [N_COUNTERS-1:0] event_vec_t;

    //----------------------------------------------------------
    // Register map
    //----------------------------------------------------------

    // Main configuration word
    localparam int CFG_IDX = 0;
    // Counters occupy words 1 to 9
    localparam int COUNTER_BASE = 1;
    // Overflow interrupt mask and sticky vector
    localparam int OVF_MASK_IDX = 10;
    localparam int OVF_VECT_IDX = 11;
    // Quota mask and limit
    localparam int QUOTA_MASK_IDX = 12;
    localparam int QUOTA_LIMIT_IDX = 13;

    // Configuration word bit positions
    localparam int CFG_EN_BIT = 0;
    localparam int CFG_SOFTRST_BIT = 1;
    localparam int CFG_OVF_EN_BIT = 2;
    localparam int CFG_OVF_SOFTRST_BIT = 3;
    localparam int CFG_QUOTA_SOFTRST_BIT = 4;
    // Self-test field, bits 31:30
    localparam int CFG_SELFTEST_LSB = 30;

    // Self-test event source
    typedef enum logic [SELFTEST_WIDTH-1:0] {
        SELFTEST_OFF     = 2'b00,  // events pass through
        SELFTEST_ALL_ON  = 2'b01,
        SELFTEST_ALL_OFF = 2'b10,
        SELFTEST_ONE_ON  = 2'b11   // only event 0 high
    } selftest_mode_e;

endpackage

// ==== source/pmu_quota.sv ====
//----------------------------------------------------------
// Quota interrupt of the PMU core
// Adds the counters selected by the mask into a registered
// sum and sets a sticky interrupt once that sum reaches the
// software limit. Counter change to interrupt is two cycles.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_quota (
    input  logic                clk_i,
    input  logic                reset_i,
    // Clears the sticky interrupt
    input  logic                softrst_i,
    input  pmu_pkg::reg_t       counts_i [pmu_pkg::N_COUNTERS],
    input  pmu_pkg::event_vec_t mask_i,
    // Quota limit word
    input  pmu_pkg::reg_t       limit_i,
    output logic                intr_quota_o
);

    //----------------------------------------------------------
    // Masked sum
    //----------------------------------------------------------

    pmu_pkg::reg_t sum_d;
    pmu_pkg::reg_t sum_q;
    logic          intr_q;

    // 32-bit wrap-around addition of the selected counters
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < pmu_pkg::N_COUNTERS; i++) begin
            if (mask_i[i]) begin
                sum_d = sum_d + counts_i[i];
            end
        end
    end

    // Sum stage breaks the adder chain from the compare
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sum_q <= '0;
        end else begin
            sum_q <= sum_d;
        end
    end

    //----------------------------------------------------------
    // Sticky interrupt
    //----------------------------------------------------------

    // Stays set until quota soft reset or reset
    always_ff @(posedge clk_i) begin
        if (reset_i || softrst_i) begin
            intr_q <= 1'b0;
        end else if (sum_q >= limit_i) begin
            intr_q <= 1'b1;
        end
    end

    assign intr_quota_o = intr_q;

endmodule

// ==== source/pmu_top.sv ====
//----------------------------------------------------------
// Interface-agnostic PMU core
// Sits behind a bus wrapper that owns the flat register
// file. Decodes the register map, feeds the counter,
// overflow and quota blocks and returns the words that the
// wrapper reads back. No state lives at this level.
//----------------------------------------------------------

`timescale 1ns/1ps

module pmu_top (
    input  logic                clk_i,
    input  logic                reset_i,
    // Wrapper register contents
    input  pmu_pkg::reg_t       regs_i [pmu_pkg::TOTAL_NREGS],
    // Values returned to the wrapper
    output pmu_pkg::reg_t       regs_o [pmu_pkg::TOTAL_NREGS],
    // Level, counters load their words while high
    input  logic                wrapper_we_i,
    input  pmu_pkg::event_vec_t events_i,
    output logic                intr_overflow_o,
    output logic                intr_quota_o
);

    //----------------------------------------------------------
    // Configuration word decode
    //----------------------------------------------------------

    logic                    cnt_en;
    logic                    cnt_softrst;
    logic                    ovf_en;
    logic                    ovf_softrst;
    logic                    quota_softrst;
    pmu_pkg::selftest_mode_e selftest_mode;

    assign cnt_en        = regs_i[pmu_pkg::CFG_IDX][pmu_pkg::CFG_EN_BIT];
    assign cnt_softrst   = regs_i[pmu_pkg::CFG_IDX][pmu_pkg::CFG_SOFTRST_BIT];
    assign ovf_en        = regs_i[pmu_pkg::CFG_IDX][pmu_pkg::CFG_OVF_EN_BIT];
    assign ovf_softrst   = regs_i[pmu_pkg::CFG_IDX][pmu_pkg::CFG_OVF_SOFTRST_BIT];
    assign quota_softrst = regs_i[pmu_pkg::CFG_IDX][pmu_pkg::CFG_QUOTA_SOFTRST_BIT];

    // Bits 31:30 select the event source
    assign selftest_mode = pmu_pkg::selftest_mode_e'(
        regs_i[pmu_pkg::CFG_IDX][pmu_pkg::CFG_SELFTEST_LSB +: pmu_pkg::SELFTEST_WIDTH]);

    //----------------------------------------------------------
    // Counter words
    //----------------------------------------------------------

    pmu_pkg::reg_t       load_values [pmu_pkg::N_COUNTERS];
    pmu_pkg::reg_t       counts      [pmu_pkg::N_COUNTERS];
    pmu_pkg::event_vec_t ovf_vect;

    for (genvar i = 0; i < pmu_pkg::N_COUNTERS; i++) begin : g_counter_words
        assign load_values[i]                   = regs_i[pmu_pkg::COUNTER_BASE + i];
        assign regs_o[pmu_pkg::COUNTER_BASE + i] = counts[i];
    end

    //----------------------------------------------------------
    // Read-back of software words
    //----------------------------------------------------------

    // Written only by the wrapper, echoed as is
    assign regs_o[pmu_pkg::CFG_IDX]         = regs_i[pmu_pkg::CFG_IDX];
    assign regs_o[pmu_pkg::OVF_MASK_IDX]    = regs_i[pmu_pkg::OVF_MASK_IDX];
    assign regs_o[pmu_pkg::QUOTA_MASK_IDX]  = regs_i[pmu_pkg::QUOTA_MASK_IDX];
    assign regs_o[pmu_pkg::QUOTA_LIMIT_IDX] = regs_i[pmu_pkg::QUOTA_LIMIT_IDX];
    // Overflow vector, zero-extended
    assign regs_o[pmu_pkg::OVF_VECT_IDX]    = pmu_pkg::reg_t'(ovf_vect);

    //----------------------------------------------------------
    // Feature blocks
    //----------------------------------------------------------

    pmu_counters u_counters (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .en_i          (cnt_en),
        .softrst_i     (cnt_softrst),
        .load_i        (wrapper_we_i),
        .selftest_i    (selftest_mode),
        .load_values_i (load_values),
        .events_i      (events_i),
        .counts_o      (counts)
    );

    pmu_overflow u_overflow (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .en_i            (ovf_en),
        .softrst_i       (ovf_softrst),
        .counts_i        (counts),
        .mask_i          (regs_i[pmu_pkg::OVF_MASK_IDX][pmu_pkg::N_COUNTERS-1:0]),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    pmu_quota u_quota (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .softrst_i    (quota_softrst),
        .counts_i     (counts),
        .mask_i       (regs_i[pmu_pkg::QUOTA_MASK_IDX][pmu_pkg::N_COUNTERS-1:0]),
        .limit_i      (regs_i[pmu_pkg::QUOTA_LIMIT_IDX]),
        .intr_quota_o (intr_quota_o)
    );

endmodule
